//--- src.f
design/video_pkg.sv
design/video_feed.sv
design/color_channel.sv
design/video_out_mux.sv
design/video_out_base.sv
test/video_out_props.sv
test/video_out_base_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the video output testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module video_out_base_tb -o sim_video_out

output=$(./obj_dir/sim_video_out 2>&1) || true
echo "$output"

if grep -q "All tests passed" <<< "$output"; then
    exit 0
fi
exit 1

//--- test/video_out_base_tb.sv
// Table-driven testbench for the video output stage
// Each row gets one pxl_cen pulse, then the DAC and sync pins are compared with a reference

`timescale 1ns/1ps

module video_out_base_tb;

    import video_pkg::*;

    localparam int reset_cycles     = 16;
    localparam int num_fixed        = 16;
    localparam int num_random       = 24;
    localparam int cycles_per_entry = 6;   // Pulse edge, sample edge, flush, margin
    localparam int timeout_cycles   = reset_cycles
                                    + (num_fixed + num_random) * cycles_per_entry + 64;

    // Flag order matches the add_row flag column
    typedef struct packed {
        logic [color_in_w-1:0] r;
        logic [color_in_w-1:0] g;
        logic [color_in_w-1:0] b;
        logic                  lhbl;
        logic                  lvbl;
        logic                  hs;
        logic                  vs;
        logic                  osd_pixel;
        logic                  osd_on;
        logic                  ypbpr;
    } stim_t;

    typedef struct packed {
        stim_t       stim;
        video_word_t word;   // Expected pins in either view
        logic        hs;
        logic        vs;
    } row_t;

    logic                   clk_sys;
    logic                   reset;
    logic                   pxl_cen;
    logic [color_in_w-1:0]  game_r;
    logic [color_in_w-1:0]  game_g;
    logic [color_in_w-1:0]  game_b;
    logic                   lhbl;
    logic                   lvbl;
    logic                   hs;
    logic                   vs;
    logic                   osd_pixel;
    logic                   osd_on;
    logic                   ypbpr;
    logic [color_out_w-1:0] VGA_R;
    logic [color_out_w-1:0] VGA_G;
    logic [color_out_w-1:0] VGA_B;
    logic                   VGA_HS;
    logic                   VGA_VS;

    row_t   rows[$];
    string  names[$];
    integer seed;
    int     cycle_count;
    logic   run_done;

    video_out_base i_video_out_base (
        .clk_sys   ( clk_sys   ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .game_r    ( game_r    ),
        .game_g    ( game_g    ),
        .game_b    ( game_b    ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .osd_pixel ( osd_pixel ),
        .osd_on    ( osd_on    ),
        .ypbpr     ( ypbpr     ),
        .VGA_R     ( VGA_R     ),
        .VGA_G     ( VGA_G     ),
        .VGA_B     ( VGA_B     ),
        .VGA_HS    ( VGA_HS    ),
        .VGA_VS    ( VGA_VS    )
    );

    bind video_out_base video_out_props i_video_out_props (
        .clk_sys ( clk_sys ),
        .reset   ( reset   ),
        .pxl_cen ( pxl_cen ),
        .hs      ( hs      ),
        .vs      ( vs      ),
        .ypbpr   ( ypbpr   ),
        .VGA_R   ( VGA_R   ),
        .VGA_G   ( VGA_G   ),
        .VGA_B   ( VGA_B   ),
        .VGA_HS  ( VGA_HS  ),
        .VGA_VS  ( VGA_VS  )
    );

    always #4 clk_sys = ~clk_sys;

    function automatic logic [color_out_w-1:0] clamp_to_dac(input int v);
        if (v < 0) begin
            return '0;
        end else if (v > (1 << color_out_w) - 1) begin
            return '1;
        end
        return color_out_w'(v);
    endfunction

    // Reference for one colour: widen, dim, tint, blank
    function automatic logic [color_out_w-1:0] expect_channel(
        input logic [color_in_w-1:0] c,
        input stim_t                 s
    );
        logic [color_out_w-1:0] v;
        v = {c, c[color_in_w-1], c[color_in_w-2]};
        if (s.osd_on) begin
            v = v >> 1;
        end
        if (s.osd_pixel) begin
            v = v | osd_tint;
        end
        if (!(s.lhbl && s.lvbl)) begin
            v = '0;
        end
        return v;
    endfunction

    function automatic video_word_t expect_word(input stim_t s);
        video_word_t w;
        int          r;
        int          g;
        int          b;
        int          y;
        r = int'(expect_channel(s.r, s));
        g = int'(expect_channel(s.g, s));
        b = int'(expect_channel(s.b, s));
        y = (2 * r + 5 * g + b) / 8;
        w = '0;
        if (s.ypbpr) begin
            w.cmp.y  = color_out_w'(y);
            w.cmp.pb = clamp_to_dac(ypbpr_offset + (b - y) / 2);  // int divide rounds to zero
            w.cmp.pr = clamp_to_dac(ypbpr_offset + (r - y) / 2);
        end else begin
            w.rgb.r = color_out_w'(r);
            w.rgb.g = color_out_w'(g);
            w.rgb.b = color_out_w'(b);
        end
        return w;
    endfunction

    // Flags are {lhbl, lvbl, hs, vs, osd_pixel, osd_on, ypbpr}
    task automatic add_row(
        input string                   name,
        input logic [3*color_in_w-1:0] rgb,
        input logic [6:0]              flags
    );
        row_t row;
        row.stim = {rgb, flags};
        row.word = expect_word(row.stim);
        row.hs   = row.stim.ypbpr ? (row.stim.hs == row.stim.vs) : row.stim.hs;
        row.vs   = row.stim.ypbpr ? 1'b1 : row.stim.vs;
        rows.push_back(row);
        names.push_back(name);
    endtask

    task automatic build_rows();
        logic [31:0] rnd;
        add_row("rgb_black",    12'h000, 7'b1100000);
        add_row("rgb_white",    12'hfff, 7'b1111000);
        add_row("rgb_ramp",     12'h18c, 7'b1110000);
        add_row("rgb_mid",      12'h73a, 7'b1101000);
        add_row("hblank_rgb",   12'hfa5, 7'b0111000);
        add_row("vblank_rgb",   12'hfa5, 7'b1010000);
        add_row("hblank_ypbpr", 12'hfa5, 7'b0110001);
        add_row("vblank_ypbpr", 12'h5af, 7'b1010001);
        add_row("osd_dim",      12'hc6f, 7'b1100010);
        add_row("osd_tint",     12'h294, 7'b1101110);
        add_row("osd_pixel",    12'h555, 7'b1110100);
        add_row("osd_blank",    12'h555, 7'b0100110); // Blank wins over tint
        add_row("ypbpr_white",  12'hfff, 7'b1111001);
        add_row("ypbpr_red",    12'hf00, 7'b1101001);
        add_row("ypbpr_blue",   12'h00f, 7'b1110001);
        add_row("ypbpr_osd",    12'h842, 7'b1100111);
        for (int i = 0; i < num_random; i++) begin
            rnd = $random(seed);
            // Blanking and OSD bits biased toward the common case
            add_row($sformatf("random_%0d", i), rnd[11:0],
                    {rnd[12] | rnd[13], rnd[14] | rnd[15], rnd[16], rnd[17],
                     rnd[18] & rnd[19], rnd[20] & rnd[21], rnd[22]});
        end
    endtask

    task automatic check_value(
        input string       what,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            run_done = 1'b1;
            $display("ERR %s expected %h actual %h", what, expected, actual);
            $display("Some tests failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic apply_row(input int idx);
        stim_t s;
        s = rows[idx].stim;
        @(posedge clk_sys);
        game_r    <= s.r;
        game_g    <= s.g;
        game_b    <= s.b;
        lhbl      <= s.lhbl;
        lvbl      <= s.lvbl;
        hs        <= s.hs;
        vs        <= s.vs;
        osd_pixel <= s.osd_pixel;
        osd_on    <= s.osd_on;
        ypbpr     <= s.ypbpr;
        pxl_cen   <= 1'b1;
        @(posedge clk_sys);
        // Feeder took the pixel here, so garbage from now on must not show
        pxl_cen   <= 1'b0;
        game_r    <= ~s.r;
        game_g    <= ~s.g;
        game_b    <= ~s.b;
        lhbl      <= ~s.lhbl;
        lvbl      <= ~s.lvbl;
        hs        <= ~s.hs;
        vs        <= ~s.vs;
        osd_pixel <= ~s.osd_pixel;
        repeat (3) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value({names[idx], " pixel"}, 32'(rows[idx].word), 32'({VGA_R, VGA_G, VGA_B}));
        check_value({names[idx], " hs"}, 32'(rows[idx].hs), 32'(VGA_HS));
        check_value({names[idx], " vs"}, 32'(rows[idx].vs), 32'(VGA_VS));
    endtask

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk_sys);
            cycle_count = cycle_count + 1;
        end
        run_done = 1'b1;
        $display("Timeout: table not finished after %0d clock cycles", cycle_count);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed      = 32'h30b7;
        run_done  = 1'b0;
        clk_sys   = 1'b0;
        reset     = 1'b1;
        pxl_cen   = 1'b0;
        game_r    = '0;
        game_g    = '0;
        game_b    = '0;
        lhbl      = 1'b0;
        lvbl      = 1'b0;
        hs        = 1'b0;
        vs        = 1'b0;
        osd_pixel = 1'b0;
        osd_on    = 1'b0;
        ypbpr     = 1'b0;
        build_rows();
        repeat (reset_cycles) @(posedge clk_sys);
        @(negedge clk_sys);
        check_value("reset colour", 32'd0, 32'({VGA_R, VGA_G, VGA_B}));
        check_value("reset sync", 32'd0, 32'({VGA_HS, VGA_VS}));
        @(posedge clk_sys);
        reset <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        run_done = 1'b1;
        $display("All tests passed");
        $finish;
    end

    // Run cut short by an assertion
    final begin
        if (!run_done) begin
            $display("Some tests failed");
        end
    end

endmodule

//--- test/video_out_props.sv
// Concurrent checks on the video output stage, bound in by the testbench
// Reset state, sync selection per mode and the YPbPr composite sync

`timescale 1ns/1ps

module video_out_props (
    input logic                              clk_sys,
    input logic                              reset,
    input logic                              pxl_cen,
    input logic                              hs,
    input logic                              vs,
    input logic                              ypbpr,
    input logic [video_pkg::color_out_w-1:0] VGA_R,
    input logic [video_pkg::color_out_w-1:0] VGA_G,
    input logic [video_pkg::color_out_w-1:0] VGA_B,
    input logic                              VGA_HS,
    input logic                              VGA_VS
);

    // Every pin low after a reset edge
    a_reset_clear: assert property (@(posedge clk_sys)
        reset |=> (VGA_R == '0 && VGA_G == '0 && VGA_B == '0 && !VGA_HS && !VGA_VS))
        else $error("VGA pins not cleared after a reset edge");

    // VS pin tied high in component mode
    a_ypbpr_vs: assert property (@(posedge clk_sys) disable iff (reset)
        ypbpr |=> VGA_VS)
        else $error("VGA_VS low after YPbPr mode was sampled");

    // Syncs taken on a pxl_cen edge reach the pins three edges later
    a_csync: assert property (@(posedge clk_sys) disable iff (reset)
        ($past(pxl_cen, 3) && $past(ypbpr)) |-> (VGA_HS == $past(hs == vs, 3)))
        else $error("VGA_HS does not carry composite sync in YPbPr mode");

    a_rgb_sync: assert property (@(posedge clk_sys) disable iff (reset)
        ($past(pxl_cen, 3) && !$past(ypbpr))
            |-> (VGA_HS == $past(hs, 3) && VGA_VS == $past(vs, 3)))
        else $error("separate syncs wrong in RGB mode");

endmodule

//--- design/video_out_base.sv
// Top level of the video output stage
// Feeder fans out to one channel per colour, the mux drives the DAC and sync pins

`timescale 1ns/1ps

module video_out_base (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic                              pxl_cen,   // Pixel clock enable
    input  logic [video_pkg::color_in_w-1:0]  game_r,
    input  logic [video_pkg::color_in_w-1:0]  game_g,
    input  logic [video_pkg::color_in_w-1:0]  game_b,
    input  logic                              lhbl,
    input  logic                              lvbl,
    input  logic                              hs,
    input  logic                              vs,
    input  logic                              osd_pixel,
    input  logic                              osd_on,
    input  logic                              ypbpr,
    output logic [video_pkg::color_out_w-1:0] VGA_R,
    output logic [video_pkg::color_out_w-1:0] VGA_G,
    output logic [video_pkg::color_out_w-1:0] VGA_B,
    output logic                              VGA_HS,
    output logic                              VGA_VS
);

    import video_pkg::*;

    logic [num_channels-1:0][color_in_w-1:0]  pix;
    logic [num_channels-1:0][color_out_w-1:0] chan_out;
    logic                                     osd_pix;
    logic                                     blank;
    logic                                     hs_q;
    logic                                     vs_q;

    video_feed i_video_feed (
        .clk_sys   ( clk_sys   ),
        .reset     ( reset     ),
        .pxl_cen   ( pxl_cen   ),
        .game_r    ( game_r    ),
        .game_g    ( game_g    ),
        .game_b    ( game_b    ),
        .lhbl      ( lhbl      ),
        .lvbl      ( lvbl      ),
        .hs        ( hs        ),
        .vs        ( vs        ),
        .osd_pixel ( osd_pixel ),
        .pix       ( pix       ),
        .osd_pix   ( osd_pix   ),
        .blank     ( blank     ),
        .hs_q      ( hs_q      ),
        .vs_q      ( vs_q      )
    );

    // Red, green, blue
    genvar i;
    generate
        for (i = 0; i < num_channels; i++) begin : g_chan
            color_channel i_color_channel (
                .clk_sys   ( clk_sys     ),
                .reset     ( reset       ),
                .color_in  ( pix[i]      ),
                .osd_on    ( osd_on      ),
                .osd_pix   ( osd_pix     ),
                .blank     ( blank       ),
                .color_out ( chan_out[i] )
            );
        end
    endgenerate

    video_out_mux i_video_out_mux (
        .clk_sys  ( clk_sys  ),
        .reset    ( reset    ),
        .ypbpr    ( ypbpr    ),
        .chan_out ( chan_out ),
        .hs_q     ( hs_q     ),
        .vs_q     ( vs_q     ),
        .VGA_R    ( VGA_R    ),
        .VGA_G    ( VGA_G    ),
        .VGA_B    ( VGA_B    ),
        .VGA_HS   ( VGA_HS   ),
        .VGA_VS   ( VGA_VS   )
    );

endmodule

//--- design/video_out_mux.sv
// Output multiplexer of the video stage
// Builds RGB or YPbPr words, forms composite sync and keeps syncs aligned with colour

`timescale 1ns/1ps

module video_out_mux (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic                              ypbpr,    // Component mode level
    input  logic [video_pkg::num_channels-1:0][video_pkg::color_out_w-1:0] chan_out,
    input  logic                              hs_q,
    input  logic                              vs_q,
    output logic [video_pkg::color_out_w-1:0] VGA_R,
    output logic [video_pkg::color_out_w-1:0] VGA_G,
    output logic [video_pkg::color_out_w-1:0] VGA_B,
    output logic                              VGA_HS,
    output logic                              VGA_VS
);

    import video_pkg::*;

    logic                   hs_d;
    logic                   vs_d;
    logic                   csync;
    logic [8:0]             y_sum;      // Up to 504
    logic [color_out_w-1:0] y_val;
    logic signed [7:0]      diff_b;
    logic signed [7:0]      diff_r;
    logic signed [9:0]      pb_full;
    logic signed [9:0]      pr_full;
    video_word_t            word_d;
    video_word_t            word_q;

    // Saturate to the DAC range
    function automatic logic [color_out_w-1:0] clamp_dac(input logic signed [9:0] v);
        logic signed [9:0] top;
        top = 10'((1 << color_out_w) - 1);
        if (v < 0) begin
            return '0;
        end else if (v > top) begin
            return top[color_out_w-1:0];
        end
        return v[color_out_w-1:0];
    endfunction

    // Colour spends one cycle in the channel, so syncs wait one here
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_d <= 1'b0;
            vs_d <= 1'b0;
        end else begin
            hs_d <= hs_q;
            vs_d <= vs_q;
        end
    end

    assign csync = (hs_d == vs_d);

    // Luma is (2R + 5G + B) / 8
    always_comb begin
        y_sum = 9'({chan_out[0], 1'b0}) + 9'({chan_out[1], 2'b00}) + 9'(chan_out[1])
              + 9'(chan_out[2]);
        y_val = y_sum[8:3];

        diff_b = $signed({2'b00, chan_out[2]}) - $signed({2'b00, y_val});
        diff_r = $signed({2'b00, chan_out[0]}) - $signed({2'b00, y_val});

        // Signed divide truncates toward zero
        pb_full = 10'(ypbpr_offset + diff_b / 2);
        pr_full = 10'(ypbpr_offset + diff_r / 2);
    end

    always_comb begin
        word_d = '0;
        if (ypbpr) begin
            word_d.cmp.pr = clamp_dac(pr_full);
            word_d.cmp.y  = y_val;
            word_d.cmp.pb = clamp_dac(pb_full);
        end else begin
            word_d.rgb.r = chan_out[0];
            word_d.rgb.g = chan_out[1];
            word_d.rgb.b = chan_out[2];
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            word_q <= '0;
            VGA_HS <= 1'b0;
            VGA_VS <= 1'b0;
        end else begin
            word_q <= word_d;
            if (ypbpr) begin
                // SCART style, composite sync on HS and VS tied high
                VGA_HS <= csync;
                VGA_VS <= 1'b1;
            end else begin
                VGA_HS <= hs_d;
                VGA_VS <= vs_d;
            end
        end
    end

    // Pin slices are the same in both views
    assign VGA_R = word_q.rgb.r;
    assign VGA_G = word_q.rgb.g;
    assign VGA_B = word_q.rgb.b;

endmodule

//--- design/color_channel.sv
// One colour channel of the video stage
// Expands 4-bit colour to DAC width, applies OSD dimming and tint, then blanking

`timescale 1ns/1ps

module color_channel (
    input  logic                              clk_sys,
    input  logic                              reset,
    input  logic [video_pkg::color_in_w-1:0]  color_in,
    input  logic                              osd_on,   // OSD menu open
    input  logic                              osd_pix,  // OSD plane lit here
    input  logic                              blank,
    output logic [video_pkg::color_out_w-1:0] color_out
);

    import video_pkg::*;

    logic [color_out_w-1:0] expanded;
    logic [color_out_w-1:0] dimmed;
    logic [color_out_w-1:0] mixed;

    always_comb begin
        // Top bits repeated below so full scale maps to full scale
        expanded = {color_in, color_in[color_in_w-1 -: (color_out_w - color_in_w)]};

        // Game picture at half brightness behind the menu
        if (osd_on) begin
            dimmed = expanded >> 1;
        end else begin
            dimmed = expanded;
        end

        if (osd_pix) begin
            mixed = dimmed | osd_tint;
        end else begin
            mixed = dimmed;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (reset) begin
            color_out <= '0;
        end else if (blank) begin
            color_out <= '0; // Black outside the active area
        end else begin
            color_out <= mixed;
        end
    end

endmodule

//--- design/video_feed.sv
// Pixel feeder for the video output stage
// Samples game colours, blanking, syncs and the OSD bit on each pxl_cen

`timescale 1ns/1ps

module video_feed (
    input  logic                         clk_sys,
    input  logic                         reset,
    input  logic                         pxl_cen,
    input  logic [video_pkg::color_in_w-1:0] game_r,
    input  logic [video_pkg::color_in_w-1:0] game_g,
    input  logic [video_pkg::color_in_w-1:0] game_b,
    input  logic                         lhbl,      // Low during horizontal blank
    input  logic                         lvbl,      // Low during vertical blank
    input  logic                         hs,
    input  logic                         vs,
    input  logic                         osd_pixel,
    output logic [video_pkg::num_channels-1:0][video_pkg::color_in_w-1:0] pix,
    output logic                         osd_pix,
    output logic                         blank,
    output logic                         hs_q,
    output logic                         vs_q
);

    logic blank_in;

    // Either blanking flag low kills the pixel
    assign blank_in = ~(lhbl & lvbl);

    // Colour capture, index 0 is red
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            pix <= '0;
        end else if (pxl_cen) begin
            pix[0] <= game_r;
            pix[1] <= game_g;
            pix[2] <= game_b;
        end
    end

    // Side band travels with the colours
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            osd_pix <= 1'b0;
            blank   <= 1'b0;
        end else if (pxl_cen) begin
            osd_pix <= osd_pixel;
            blank   <= blank_in;
        end
    end

    // Syncs sampled on the same strobe
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            hs_q <= 1'b0;
            vs_q <= 1'b0;
        end else if (pxl_cen) begin
            hs_q <= hs;
            vs_q <= vs;
        end
    end

endmodule

//--- design/video_pkg.sv
// Shared widths, colour constants and the output word of the video stage
// Imported by the feeder, channel, mux and top level

package video_pkg;

    // Game side pixel, 4 bits per colour
    localparam int color_in_w = 4;

    // DAC side pixel, 6 bits per colour
    localparam int color_out_w = 6;

    // Red, green, blue in that index order
    localparam int num_channels = 3;

    // Bits forced high where the OSD plane is lit
    localparam logic [color_out_w-1:0] osd_tint = 6'h30;

    // Mid-scale bias for Pb and Pr
    localparam int ypbpr_offset = 32;

    // Plain RGB view of the output word
    typedef struct packed {
        logic [color_out_w-1:0] r;
        logic [color_out_w-1:0] g;
        logic [color_out_w-1:0] b;
    } rgb_view_t;

    // Component view, same pin order as RGB
    typedef struct packed {
        logic [color_out_w-1:0] pr; // On the red pin
        logic [color_out_w-1:0] y;  // On the green pin
        logic [color_out_w-1:0] pb; // On the blue pin
    } ypbpr_view_t;

    // One 18-bit word, decoded by mode
    typedef union packed {
        rgb_view_t   rgb;
        ypbpr_view_t cmp;
    } video_word_t;

endpackage
